/* project.f */
hw/ppu_pkg.sv
hw/ppu_regs.sv
hw/ppu_vram.sv
hw/ppu_timing.sv
hw/ppu_bg_render.sv
hw/ppu_top.sv
dv/ppu_tb.sv

/* run_sim.sh */
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -sv -Wno-fatal \
  -f project.f --top-module ppu_tb -Mdir obj_dir -o ppu_sim > build.log 2>&1 \
  && ./obj_dir/ppu_sim > sim.log 2>&1 \
  ; grep -q "^Regression passed$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* dv/ppu_tb.sv */
`timescale 1ns/10ps

module ppu_tb;
  import ppu_pkg::*;

  localparam logic [31:0] seed = 32'h13c885a5;
  localparam int frame_clocks  = int'(dots_per_line) * int'(lines_per_frame);
  localparam int pipe_depth    = 3;    // Issue to pixel output
  localparam int vram_checks   = 300;
  localparam int stat_polls    = 300;
  localparam int poll_gap      = 233;  // Spreads polls over a frame

  logic   clk;
  logic   reset;
  addr_t  cpu_addr;
  byte_t  cpu_wdata;
  logic   cpu_write;
  logic   cpu_read;
  byte_t  cpu_rdata;
  logic   vblank;
  logic   pixel_valid;
  pixel_x_t pixel_x;
  line_t  pixel_y;
  shade_t pixel_shade;

  logic [31:0] lfsr = seed;
  int errors = 0;
  int timeouts = 0;
  int since_vblank = 0;
  int pixel_count = 0;
  logic render_armed = 1'b0;

  // Shadow copies of everything the CPU wrote
  byte_t shadow_vram [8192];
  byte_t shadow_lcdc = 8'h00;
  byte_t shadow_scy  = 8'h00;
  byte_t shadow_scx  = 8'h00;
  byte_t shadow_lyc  = 8'h00;
  byte_t shadow_bgp  = 8'hFC;

  ppu_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] result;
    logic lsb;
    result = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 32'hA3000000;  // Galois taps
      result = {result[30:0], lsb};
    end
    return result;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %0h expected %0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic cpu_write_byte(input addr_t addr, input byte_t data);
    @(negedge clk);
    cpu_addr  = addr;
    cpu_wdata = data;
    cpu_read  = 1'b0;
    cpu_write = 1'b1;
    @(negedge clk);
    cpu_write = 1'b0;
    if (addr >= vram_base && addr <= vram_last) shadow_vram[addr - vram_base] = data;
    case (addr)
      addr_lcdc: shadow_lcdc = data;
      addr_scy:  shadow_scy  = data;
      addr_scx:  shadow_scx  = data;
      addr_lyc:  shadow_lyc  = data;
      addr_bgp:  shadow_bgp  = data;
      default: ;
    endcase
  endtask

  task automatic cpu_read_byte(input addr_t addr, output byte_t data);
    @(negedge clk);
    cpu_addr = addr;
    cpu_read = 1'b1;
    #10 data = cpu_rdata;  // Settled well before the next rising edge
    @(negedge clk);
    cpu_read = 1'b0;
  endtask

  task automatic wait_vblank(input int limit, output int clocks);
    clocks = 0;
    do begin
      @(negedge clk);
      clocks++;
    end while (!vblank && clocks < limit);
    if (!vblank) begin
      $display("Timeout: no vblank pulse within %0d clocks", limit);
      timeouts++;
    end
  endtask

  // Background shade from the shadow state
  function automatic shade_t ref_pixel(input int x, input int y);
    int sx, sy, fine;
    int map_off, tile_num, row_off;
    byte_t lo, hi;
    logic [1:0] color;
    sx = (x + shadow_scx) % 256;
    sy = (y + shadow_scy) % 256;
    fine = sx % 8;
    map_off = (shadow_lcdc[3] ? 'h1C00 : 'h1800) + 32 * (sy / 8) + sx / 8;
    tile_num = shadow_vram[map_off];
    if (shadow_lcdc[4]) begin
      row_off = tile_num * 16;
    end else begin
      if (tile_num > 127) tile_num = tile_num - 256;  // Signed tile index
      row_off = 'h1000 + tile_num * 16;
    end
    row_off = row_off + 2 * (sy % 8);
    lo = shadow_vram[row_off];
    hi = shadow_vram[row_off + 1];
    color = {hi[7 - fine], lo[7 - fine]};
    if (!shadow_lcdc[0]) return 2'b00;
    return shadow_bgp[2 * int'(color) +: 2];
  endfunction

  // ====================
  // Pixel monitor
  // ====================
  // Frame position counted from the last vblank pulse at ly 144
  always @(negedge clk) begin : pixel_monitor
    int line_no;
    int dot_no;
    int exp_x;
    logic exp_valid;
    if (vblank) since_vblank = 0;
    else since_vblank = since_vblank + 1;
    if (render_armed) begin
      line_no = (int'(visible_lines) + since_vblank / int'(dots_per_line))
                % int'(lines_per_frame);
      dot_no = since_vblank % int'(dots_per_line);
      exp_x = dot_no - int'(draw_start) - pipe_depth;
      exp_valid = (line_no < int'(visible_lines)) &&
                  (dot_no >= int'(draw_start) + pipe_depth) &&
                  (dot_no < int'(draw_start) + int'(screen_width) + pipe_depth);
      check_equal("pixel_valid", pixel_valid, exp_valid);
      if (pixel_valid && exp_valid) begin
        check_equal("pixel_x", pixel_x, exp_x);
        check_equal("pixel_y", pixel_y, line_no);
        check_equal("pixel_shade", pixel_shade, ref_pixel(exp_x, line_no));
        pixel_count++;
      end
    end
  end

  // One whole frame checked pixel by pixel
  task automatic check_frame();
    int clocks;
    wait_vblank(frame_clocks + 2000, clocks);
    pixel_count = 0;
    render_armed = 1'b1;
    wait_vblank(frame_clocks + 10, clocks);
    render_armed = 1'b0;
    check_equal("pixels per frame", pixel_count,
                int'(screen_width) * int'(visible_lines));
  endtask

  // ====================
  // Scenarios
  // ====================
  initial begin
    byte_t data, stat_val, ly_a, ly_b;
    addr_t addr;
    addr_t written[$];
    int clocks, off_valid, off_vblank;

    reset = 1'b1;
    cpu_addr = '0;
    cpu_wdata = '0;
    cpu_write = 1'b0;
    cpu_read = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    // Reset values and unmapped space
    cpu_read_byte(addr_ly, data);
    check_equal("LY", data, 8'h00);
    cpu_read_byte(addr_bgp, data);
    check_equal("BGP", data, 8'hFC);
    cpu_read_byte(16'hFE00 + addr_t'(rand_bits(8) % 160), data);
    check_equal("OAM read", data, 8'hFF);
    cpu_read_byte(16'hFF4A, data);
    check_equal("unmapped read", data, 8'hFF);
    cpu_read_byte(addr_stat, stat_val);
    check_equal("STAT", stat_val, 8'h84);  // Display off and LY equal to LYC
    cpu_write_byte(addr_stat, byte_t'(rand_bits(8)));
    cpu_read_byte(addr_stat, data);
    check_equal("STAT after write", data, stat_val);

    for (int i = 0; i < 8; i++) begin
      cpu_write_byte(addr_scy, byte_t'(rand_bits(8)));
      cpu_write_byte(addr_scx, byte_t'(rand_bits(8)));
      cpu_write_byte(addr_lyc, byte_t'(rand_bits(8)));
      cpu_write_byte(addr_bgp, byte_t'(rand_bits(8)));
      cpu_write_byte(addr_lcdc, byte_t'(rand_bits(7)));  // Display stays off
      cpu_read_byte(addr_scy, data);
      check_equal("SCY", data, shadow_scy);
      cpu_read_byte(addr_scx, data);
      check_equal("SCX", data, shadow_scx);
      cpu_read_byte(addr_lyc, data);
      check_equal("LYC", data, shadow_lyc);
      cpu_read_byte(addr_bgp, data);
      check_equal("BGP", data, shadow_bgp);
      cpu_read_byte(addr_lcdc, data);
      check_equal("LCDC", data, shadow_lcdc);
    end

    // VRAM random access
    for (int i = 0; i < vram_checks; i++) begin
      addr = vram_base + addr_t'(rand_bits(13));
      cpu_write_byte(addr, byte_t'(rand_bits(8)));
      written.push_back(addr);
    end
    foreach (written[i]) begin
      cpu_read_byte(written[i], data);
      check_equal("VRAM read", data, shadow_vram[written[i] - vram_base]);
    end

    // Whole VRAM filled for rendering
    for (int a = 0; a < 8192; a++) begin
      cpu_write_byte(vram_base + addr_t'(a), byte_t'(rand_bits(8)));
    end

    // Frame timing
    cpu_write_byte(addr_lcdc, 8'h91);
    wait_vblank(frame_clocks + 2000, clocks);
    wait_vblank(frame_clocks + 10, clocks);
    check_equal("vblank interval", clocks, frame_clocks);
    check_frame();

    // All four ways of map select and tile addressing
    for (int c = 0; c < 4; c++) begin
      cpu_write_byte(addr_scx, byte_t'(rand_bits(8)));
      cpu_write_byte(addr_scy, byte_t'(rand_bits(8)));
      cpu_write_byte(addr_bgp, byte_t'(rand_bits(8)));
      cpu_write_byte(addr_lcdc, byte_t'(8'h81 | (c[0] << 3) | (c[1] << 4)));
      check_frame();
    end

    // Two LY reads bracket each STAT read
    cpu_write_byte(addr_lyc, byte_t'(rand_bits(8) % lines_per_frame));
    for (int i = 0; i < stat_polls; i++) begin
      cpu_read_byte(addr_ly, ly_a);
      cpu_read_byte(addr_stat, stat_val);
      cpu_read_byte(addr_ly, ly_b);
      if (ly_a == ly_b) begin
        check_equal("STAT bit 7", stat_val[7], 1'b1);
        check_equal("STAT vblank mode", stat_val[1:0] == 2'd1, ly_a >= visible_lines);
        check_equal("STAT LYC match", stat_val[2], ly_a == shadow_lyc);
      end
      repeat (poll_gap) @(negedge clk);
    end

    // Background disabled
    cpu_write_byte(addr_lcdc, byte_t'(8'h80 | (rand_bits(2) << 3)));
    check_frame();

    // Display off
    cpu_write_byte(addr_lcdc, 8'h00);
    repeat (8) @(negedge clk);  // Pipeline drains
    off_valid = 0;
    off_vblank = 0;
    for (int i = 0; i < 2 * frame_clocks; i++) begin
      @(negedge clk);
      off_valid += pixel_valid;
      off_vblank += vblank;
    end
    check_equal("pixel_valid while off", off_valid, 0);
    check_equal("vblank while off", off_vblank, 0);
    cpu_read_byte(addr_ly, data);
    check_equal("LY while off", data, 8'h00);

    $display("Done with %0d mismatches and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* hw/ppu_top.sv */
`timescale 1ns/10ps

module ppu_top (
  input  logic              clk,
  input  logic              reset,
  input  ppu_pkg::addr_t    cpu_addr,
  input  ppu_pkg::byte_t    cpu_wdata,
  input  logic              cpu_write,
  input  logic              cpu_read,
  output ppu_pkg::byte_t    cpu_rdata,
  output logic              vblank,
  output logic              pixel_valid,
  output ppu_pkg::pixel_x_t pixel_x,
  output ppu_pkg::line_t    pixel_y,
  output ppu_pkg::shade_t   pixel_shade
);
  import ppu_pkg::*;

  // CPU side of VRAM
  logic        vram_cpu_write;
  vram_addr_t  vram_cpu_addr;
  byte_t       vram_cpu_wdata;
  byte_t       vram_cpu_rdata;

  // Register fields
  logic        lcd_on;
  line_t       lyc;
  byte_t       scx;
  byte_t       scy;
  byte_t       bgp;
  logic        bg_enable;
  logic        map_select;
  logic        tile_unsigned;

  // Timing
  dot_t        dot;
  line_t       ly;
  ppu_mode_e   mode;
  logic        lyc_match;

  // Render fetch
  vram_addr_t  map_addr;
  logic [11:0] tile_addr;
  byte_t       map_data;
  logic [15:0] tile_data;

  ppu_regs regs_i (.*);

  ppu_vram vram_i (
    .clk       (clk),
    .cpu_write (vram_cpu_write),
    .cpu_addr  (vram_cpu_addr),
    .cpu_wdata (vram_cpu_wdata),
    .cpu_rdata (vram_cpu_rdata),
    .map_addr  (map_addr),
    .tile_addr (tile_addr),
    .map_data  (map_data),
    .tile_data (tile_data)
  );

  ppu_timing timing_i (.*);

  ppu_bg_render render_i (.*);

endmodule

/* hw/ppu_bg_render.sv */
`timescale 1ns/10ps

module ppu_bg_render (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::dot_t       dot,
  input  ppu_pkg::line_t      ly,
  input  ppu_pkg::ppu_mode_e  mode,
  input  ppu_pkg::byte_t      scx,
  input  ppu_pkg::byte_t      scy,
  input  ppu_pkg::byte_t      bgp,
  input  logic                bg_enable,
  input  logic                map_select,
  input  logic                tile_unsigned,
  output ppu_pkg::vram_addr_t map_addr,
  output logic [11:0]         tile_addr,
  input  ppu_pkg::byte_t      map_data,
  input  logic [15:0]         tile_data,
  output logic                pixel_valid,
  output ppu_pkg::pixel_x_t   pixel_x,
  output ppu_pkg::line_t      pixel_y,
  output ppu_pkg::shade_t     pixel_shade
);
  import ppu_pkg::*;

  localparam vram_addr_t map_base_lo = 13'h1800;  // 9800 map
  localparam vram_addr_t map_base_hi = 13'h1C00;  // 9C00 map

  // Stage 0
  logic       issue;
  pixel_x_t   x0;
  byte_t      sx0;
  byte_t      sy0;

  // Stage 1
  logic       s1_valid;
  pixel_x_t   s1_x;
  line_t      s1_y;
  logic [2:0] s1_fine_x;
  logic [2:0] s1_row;

  // Stage 2
  logic       s2_valid;
  pixel_x_t   s2_x;
  line_t      s2_y;
  logic [2:0] s2_fine_x;
  logic [2:0] bit_sel;
  shade_t     color;

  // ====================
  // Stage 0, map fetch
  // ====================
  always_comb begin
    issue    = (mode == mode_draw) && (dot < draw_start + screen_width);
    x0       = pixel_x_t'(dot - draw_start);
    sx0      = x0 + scx;  // Wraps at 256
    sy0      = ly + scy;
    map_addr = (map_select ? map_base_hi : map_base_lo) + {3'b000, sy0[7:3], sx0[7:3]};
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      pixel_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
      s2_valid <= s1_valid;
      pixel_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_x      <= x0;
    s1_y      <= ly;
    s1_fine_x <= sx0[2:0];
    s1_row    <= sy0[2:0];
  end

  // ====================
  // Stage 1, tile row fetch
  // ====================
  // Signed mode: 0x800 + signed tile * 8 folds into flipping the sign bit
  assign tile_addr = tile_unsigned ? {1'b0, map_data, s1_row}
                                   : {~map_data[7], map_data, s1_row};

  always_ff @(posedge clk) begin
    s2_x      <= s1_x;
    s2_y      <= s1_y;
    s2_fine_x <= s1_fine_x;
  end

  // ====================
  // Stage 2, pixel and palette
  // ====================
  always_comb begin
    bit_sel = 3'd7 - s2_fine_x;  // Leftmost pixel is bit 7
    color   = {tile_data[{1'b1, bit_sel}], tile_data[{1'b0, bit_sel}]};
  end

  always_ff @(posedge clk) begin
    pixel_x     <= s2_x;
    pixel_y     <= s2_y;
    pixel_shade <= bg_enable ? bgp[{color, 1'b0} +: 2] : 2'b00;
  end

  assert property (@(posedge clk) disable iff (reset) pixel_valid |-> pixel_x < screen_width);

endmodule

/* hw/ppu_timing.sv */
`timescale 1ns/10ps

module ppu_timing (
  input  logic               clk,
  input  logic               reset,
  input  logic               lcd_on,
  input  ppu_pkg::line_t     lyc,
  output ppu_pkg::dot_t      dot,
  output ppu_pkg::line_t     ly,
  output ppu_pkg::ppu_mode_e mode,
  output logic               vblank,
  output logic               lyc_match
);
  import ppu_pkg::*;

  logic running;  // Low for the first cycle after LCD turn-on
  logic line_end;

  assign line_end  = (dot == dots_per_line - 9'd1);
  assign lyc_match = (ly == lyc);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot     <= '0;
      ly      <= '0;
      mode    <= mode_oam;
      vblank  <= 1'b0;
      running <= 1'b0;
    end else if (!lcd_on) begin
      // Display off, everything parked
      dot     <= '0;
      ly      <= '0;
      mode    <= mode_hblank;
      vblank  <= 1'b0;
      running <= 1'b0;
    end else if (!running) begin
      dot     <= '0;
      ly      <= '0;
      mode    <= mode_oam;
      vblank  <= 1'b0;
      running <= 1'b1;
    end else begin
      vblank <= 1'b0;

      // Dot and line counters
      if (line_end) begin
        dot <= '0;
        ly  <= (ly == lines_per_frame - 8'd1) ? 8'd0 : ly + 8'd1;
      end else begin
        dot <= dot + 9'd1;
      end

      // Mode sequence 2 -> 3 -> 0, then 1 after the last visible line
      case (mode)
        mode_oam: if (dot == draw_start - 9'd1) mode <= mode_draw;
        mode_draw: if (dot == draw_end - 9'd1) mode <= mode_hblank;
        mode_hblank: begin
          if (line_end) begin
            if (ly == visible_lines - 8'd1) begin
              mode   <= mode_vblank;
              vblank <= 1'b1;  // Lines up with ly becoming 144
            end else begin
              mode <= mode_oam;
            end
          end
        end
        mode_vblank: if (line_end && ly == lines_per_frame - 8'd1) mode <= mode_oam;
        default: mode <= mode_hblank;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (reset) dot < dots_per_line);
  assert property (@(posedge clk) disable iff (reset) ly < lines_per_frame);

endmodule

/* hw/ppu_vram.sv */
`timescale 1ns/10ps

module ppu_vram (
  input  logic                clk,
  input  logic                cpu_write,
  input  ppu_pkg::vram_addr_t cpu_addr,
  input  ppu_pkg::byte_t      cpu_wdata,
  output ppu_pkg::byte_t      cpu_rdata,
  input  ppu_pkg::vram_addr_t map_addr,
  input  logic [11:0]         tile_addr,  // Row-pair index
  output ppu_pkg::byte_t      map_data,
  output logic [15:0]         tile_data
);
  import ppu_pkg::*;

  // Even and odd bytes kept apart so a tile row reads in one go
  byte_t even_mem [4096];
  byte_t odd_mem  [4096];

  always_ff @(posedge clk) begin
    if (cpu_write) begin
      if (cpu_addr[0]) begin
        odd_mem[cpu_addr[12:1]] <= cpu_wdata;
      end else begin
        even_mem[cpu_addr[12:1]] <= cpu_wdata;
      end
    end
  end

  // CPU side is combinational
  assign cpu_rdata = cpu_addr[0] ? odd_mem[cpu_addr[12:1]] : even_mem[cpu_addr[12:1]];

  // Render ports, one cycle latency
  always_ff @(posedge clk) begin
    if (map_addr[0]) begin
      map_data <= odd_mem[map_addr[12:1]];
    end else begin
      map_data <= even_mem[map_addr[12:1]];
    end
    tile_data <= {odd_mem[tile_addr], even_mem[tile_addr]};  // High plane on top
  end

endmodule

/* hw/ppu_regs.sv */
`timescale 1ns/10ps

module ppu_regs (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::addr_t      cpu_addr,
  input  ppu_pkg::byte_t      cpu_wdata,
  input  logic                cpu_write,
  input  logic                cpu_read,
  output ppu_pkg::byte_t      cpu_rdata,
  input  ppu_pkg::line_t      ly,
  input  ppu_pkg::ppu_mode_e  mode,
  input  logic                lyc_match,
  output logic                vram_cpu_write,
  output ppu_pkg::vram_addr_t vram_cpu_addr,
  output ppu_pkg::byte_t      vram_cpu_wdata,
  input  ppu_pkg::byte_t      vram_cpu_rdata,
  output logic                lcd_on,
  output ppu_pkg::line_t      lyc,
  output ppu_pkg::byte_t      scx,
  output ppu_pkg::byte_t      scy,
  output ppu_pkg::byte_t      bgp,
  output logic                bg_enable,
  output logic                map_select,
  output logic                tile_unsigned
);
  import ppu_pkg::*;

  byte_t lcdc;
  logic  vram_hit;

  assign vram_hit = (cpu_addr >= vram_base) && (cpu_addr <= vram_last);

  // VRAM window goes straight through
  assign vram_cpu_write = cpu_write && vram_hit;
  assign vram_cpu_addr  = vram_addr_t'(cpu_addr - vram_base);
  assign vram_cpu_wdata = cpu_wdata;

  // LCDC fields
  assign lcd_on        = lcdc[7];
  assign tile_unsigned = lcdc[4];  // 8000 addressing
  assign map_select    = lcdc[3];  // 9C00 map
  assign bg_enable     = lcdc[0];

  // ====================
  // Register writes
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc <= 8'h00;
      scy  <= 8'h00;
      scx  <= 8'h00;
      lyc  <= 8'h00;
      bgp  <= 8'hFC;
    end else if (cpu_write) begin
      case (cpu_addr)
        addr_lcdc: lcdc <= cpu_wdata;
        addr_scy:  scy  <= cpu_wdata;
        addr_scx:  scx  <= cpu_wdata;
        addr_lyc:  lyc  <= cpu_wdata;
        addr_bgp:  bgp  <= cpu_wdata;
        default: ;  // STAT, LY and OAM writes dropped
      endcase
    end
  end

  // ====================
  // Read mux
  // ====================
  always_comb begin
    cpu_rdata = 8'hFF;  // Idle, unmapped and OAM
    if (cpu_read) begin
      if (vram_hit) begin
        cpu_rdata = vram_cpu_rdata;
      end else begin
        case (cpu_addr)
          addr_lcdc: cpu_rdata = lcdc;
          addr_stat: cpu_rdata = {1'b1, 4'b0000, lyc_match, mode};
          addr_scy:  cpu_rdata = scy;
          addr_scx:  cpu_rdata = scx;
          addr_ly:   cpu_rdata = ly;
          addr_lyc:  cpu_rdata = lyc;
          addr_bgp:  cpu_rdata = bgp;
          default:   cpu_rdata = 8'hFF;
        endcase
      end
    end
  end

  // Bus master never reads and writes in one cycle
  assert property (@(posedge clk) disable iff (reset) !(cpu_read && cpu_write));

endmodule

/* hw/ppu_pkg.sv */
package ppu_pkg;

  // ====================
  // Widths with a meaning
  // ====================
  typedef logic [15:0] addr_t;       // CPU address
  typedef logic [7:0]  byte_t;       // Bus data, register contents
  typedef logic [12:0] vram_addr_t;  // Offset into video RAM
  typedef logic [8:0]  dot_t;        // 0..455
  typedef logic [7:0]  line_t;       // 0..153
  typedef logic [7:0]  pixel_x_t;    // 0..159
  typedef logic [1:0]  shade_t;      // Color index or palette shade

  // Encoding matches the STAT mode field
  typedef enum logic [1:0] {
    mode_hblank = 2'd0,
    mode_vblank = 2'd1,
    mode_oam    = 2'd2,
    mode_draw   = 2'd3
  } ppu_mode_e;

  // ====================
  // Display format
  // ====================
  localparam dot_t  dots_per_line   = 9'd456;
  localparam line_t lines_per_frame = 8'd154;
  localparam line_t visible_lines   = 8'd144;
  localparam dot_t  screen_width    = 9'd160;
  localparam dot_t  draw_start      = 9'd80;   // First dot of mode 3
  localparam dot_t  draw_end        = 9'd252;  // First dot of mode 0

  // ====================
  // Register map
  // ====================
  localparam addr_t addr_lcdc = 16'hFF40;
  localparam addr_t addr_stat = 16'hFF41;
  localparam addr_t addr_scy  = 16'hFF42;
  localparam addr_t addr_scx  = 16'hFF43;
  localparam addr_t addr_ly   = 16'hFF44;
  localparam addr_t addr_lyc  = 16'hFF45;
  localparam addr_t addr_bgp  = 16'hFF47;

  localparam addr_t vram_base = 16'h8000;
  localparam addr_t vram_last = 16'h9FFF;

endpackage
